/* arkanoid_input.f */
+incdir+rtl
rtl/arkanoid_input_pkg.sv
rtl/ps2_key_decoder.sv
rtl/spinner_emulator.sv
rtl/encoder_halver.sv
rtl/dip_switch_bank.sv
rtl/input_control.sv
rtl/arkanoid_input.sv
tb/arkanoid_input_sva.sv
tb/tb_arkanoid_input.sv

/* Bender.yml */
package:
  name: arkanoid_input

export_include_dirs:
  - rtl

sources:
  - files:
      - rtl/arkanoid_input_pkg.sv
      - rtl/ps2_key_decoder.sv
      - rtl/spinner_emulator.sv
      - rtl/encoder_halver.sv
      - rtl/dip_switch_bank.sv
      - rtl/input_control.sv
      - rtl/arkanoid_input.sv
  - target: test
    files:
      - tb/arkanoid_input_sva.sv
      - tb/tb_arkanoid_input.sv

/* tb/tb_arkanoid_input.sv */
/*
 * Testbench for the paddle-game input front end
 * Clock and reset, LFSR, bus and event tasks, five tests,
 * per-test report lines and the run timeout
 */
`include "arkanoid_input_settings.svh"

module tb_arkanoid_input;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int STEP_CYC    = 3000;	// Clocks per quadrature step
	localparam int POLL_CYC    = 96000;	// Clocks per pad poll
	localparam int MOUSE_CYC   = 2 * (15 + 3) * STEP_CYC;	// Two moves of up to 15 steps
	localparam int PAD_CYC     = POLL_CYC + (3 + 10 + 2) * STEP_CYC;
	localparam int TIMEOUT_CYC = MOUSE_CYC + PAD_CYC + 20000;	// Bus, keys, encoder, margin
	localparam logic [1:0] POS_ORDER [4] = '{2'b00, 2'b10, 2'b11, 2'b01};

	logic CLK_12M = 1'b0;
	logic rst_n;
	arkanoid_input_pkg::ps2_key_t  ps2_key;
	arkanoid_input_pkg::mouse_t    mouse;
	arkanoid_input_pkg::pad_t      pad;
	arkanoid_input_pkg::enc_pins_t enc_pins;
	arkanoid_input_pkg::apb_req_t  apb_req;
	arkanoid_input_pkg::apb_rsp_t  apb_rsp;
	arkanoid_input_pkg::game_in_t  game;
	arkanoid_input_pkg::dip_t      dip_sw;

	logic [31:0] lfsr = 32'd93212;
	int errors = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int mark;	// Failure total when the test began
	int cycle_cnt;
	arkanoid_input_pkg::quad_t emu_exp;	// Expected emulated phase
	arkanoid_input_pkg::quad_t enc_exp;

	arkanoid_input i_dut (.*);

	always #4 CLK_12M = ~CLK_12M;	// 8 ns period

	////////////////////////////////////////////////////////////
	// Helpers
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);	// Taps 32 22 2 1
	endfunction

	function automatic logic [7:0] rand_bits(input int n);
		logic [7:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);	// One step per bit
			v = {v[6:0], lfsr[0]};
		end
		return v;
	endfunction

	// Next phase along 00 10 11 01 or back along it
	function automatic logic [1:0] order_step(input logic [1:0] cur, input logic pos);
		int idx;
		idx = 0;
		for (int i = 0; i < 4; i++)
			if (POS_ORDER[i] == cur)
				idx = i;
		return pos ? POS_ORDER[(idx + 1) % 4] : POS_ORDER[(idx + 3) % 4];
	endfunction

	function automatic int fail_total();
		return errors + i_dut.i_sva.fail_cnt;
	endfunction

	task automatic tick(input int n = 1);
		repeat (n) @(posedge CLK_12M);
		#1;	// Drive and sample just after the edge
	endtask

	task automatic check(input string name, input logic [7:0] got, input logic [7:0] exp);
		assert (got === exp) else begin
			$display("Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic report_problem(input string msg);
		$display("At %0t ns: %s", $time, msg);
		errors++;
	endtask

	task automatic test_end(input string name);
		tests_run++;
		if (fail_total() != mark) begin
			tests_failed++;
			$display("Test %s: FAIL", name);
		end else begin
			$display("Test %s: pass", name);
		end
	endtask

	// Setup then access with pslverr taken mid access and prdata after it
	task automatic apb_access(input logic wr, input logic [3:0] addr, input logic [7:0] wdata,
		output logic [7:0] rdata, output logic err);
		apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
		tick();
		apb_req.penable = 1'b1;
		@(negedge CLK_12M);
		err = apb_rsp.pslverr;
		tick();
		apb_req = '0;
		rdata = apb_rsp.prdata;
	endtask

	task automatic send_key(input logic [7:0] code, input logic pressed);
		ps2_key = '{toggle: ~ps2_key.toggle, pressed: pressed, code: code};
		tick(2);	// Game outputs move on the second edge
	endtask

	task automatic send_mouse(input logic signed [8:0] dx);
		mouse = '{toggle: ~mouse.toggle, btn: 2'b00, dx: dx};
	endtask

	task automatic wait_spin_change(input int limit, output logic moved);
		arkanoid_input_pkg::quad_t last;
		int n;
		last = game.spinner;
		n = 0;
		moved = 1'b0;
		while (!moved && n < limit) begin
			tick();
			n++;
			moved = (game.spinner !== last);
		end
	endtask

	task automatic follow_steps(input int count, input logic pos, input int first_wait);
		logic moved;
		for (int i = 0; i < count; i++) begin
			wait_spin_change((i == 0) ? first_wait : STEP_CYC + 10, moved);
			if (!moved) begin
				report_problem($sformatf("spinner stopped after %0d of %0d steps", i, count));
				return;
			end
			emu_exp = order_step(emu_exp, pos);
			check("game.spinner", 8'(game.spinner), 8'(emu_exp));
		end
	endtask

	task automatic expect_still(input string what);
		logic moved;
		wait_spin_change(2 * STEP_CYC, moved);
		if (moved)
			report_problem({"spinner kept moving ", what});
	endtask

	////////////////////////////////////////////////////////////
	// Tests
	initial begin
		logic [7:0] data;
		logic [7:0] rd;
		logic       err;
		logic       moved;
		logic       a;
		int         n;
		arkanoid_input_pkg::game_in_t idle;
		rst_n    = 1'b0;
		ps2_key  = '0;
		mouse    = '0;
		pad      = '0;
		enc_pins = '{enc_a: 1'b0, enc_b: 1'b0, fire_n: 1'b1};
		apb_req  = '0;
		emu_exp  = 2'b11;	// Both phases leave reset at 11
		enc_exp  = 2'b11;
		tick(5);
		rst_n = 1'b1;
		tick();

		// DIP bank
		mark = fail_total();
		check("dip_sw", dip_sw, 8'hFF);
		data = rand_bits(8);
		apb_access(1'b1, `ARK_ADDR_DIP, data, rd, err);
		check("dip_sw", dip_sw, ~data);
		apb_access(1'b0, `ARK_ADDR_DIP, 8'h00, rd, err);
		check("prdata", rd, data);
		check("pslverr", 8'(err), 8'h00);
		apb_access(1'b0, 4'h5, 8'h00, rd, err);	// Unmapped
		check("pslverr", 8'(err), 8'h01);
		check("prdata", rd, 8'h00);
		test_end("dip bank");

		// Key press then release
		mark = fail_total();
		send_key(`ARK_KEY_FIRE, 1'b1);
		check("game.shot_n", 8'(game.shot_n), 8'h00);
		send_key(`ARK_KEY_FIRE, 1'b0);
		check("game.shot_n", 8'(game.shot_n), 8'h01);
		send_key(`ARK_KEY_COIN1, 1'b1);
		check("game.coin1", 8'(game.coin1), 8'h01);
		send_key(`ARK_KEY_COIN1, 1'b0);
		check("game.coin1", 8'(game.coin1), 8'h00);
		send_key(`ARK_KEY_START1, 1'b1);
		check("game.start1_n", 8'(game.start1_n), 8'h00);
		send_key(`ARK_KEY_START1, 1'b0);
		check("game.start1_n", 8'(game.start1_n), 8'h01);
		send_key(`ARK_KEY_SERVICE, 1'b1);
		check("game.service_n", 8'(game.service_n), 8'h00);
		send_key(`ARK_KEY_SERVICE, 1'b0);
		check("game.service_n", 8'(game.service_n), 8'h01);
		// All buttons released, spinner untouched so far
		idle = '{spinner: emu_exp, shot_n: 1'b1, service_n: 1'b1, start1_n: 1'b1,
			start2_n: 1'b1, coin1: 1'b0, coin2: 1'b0};
		send_key(8'h1C, 1'b1);	// Not a cabinet key
		check("game", game, idle);
		test_end("keys");

		// Mouse spinner moved once each way
		mark = fail_total();
		n = int'(rand_bits(4));
		if (n == 0)
			n = 1;
		send_mouse(9'(n));
		follow_steps(n, 1'b1, STEP_CYC + 10);
		expect_still("after the positive move");
		n = int'(rand_bits(4));
		if (n == 0)
			n = 1;
		send_mouse(-9'(n));
		follow_steps(n, 1'b0, STEP_CYC + 10);
		expect_still("after the negative move");
		test_end("mouse spinner");

		// Pad right held with fast until three steps after the first poll
		mark = fail_total();
		pad.right = 1'b1;
		pad.fast  = 1'b1;
		follow_steps(3, 1'b1, POLL_CYC + STEP_CYC + 10);
		pad = '0;
		n = 0;
		moved = 1'b1;
		while (moved && n <= 9) begin
			wait_spin_change(STEP_CYC + 10, moved);
			if (moved) begin
				n++;
				emu_exp = order_step(emu_exp, 1'b1);
				check("game.spinner", 8'(game.spinner), 8'(emu_exp));
			end
		end
		if (moved)
			report_problem("spinner still stepping nine steps after pad release");
		test_end("pad spinner");

		// Encoder source driven by A edges with random B
		mark = fail_total();
		apb_access(1'b1, `ARK_ADDR_CTRL, 8'h01, rd, err);
		a = 1'b0;
		for (int i = 0; i < 4; i++) begin
			a = ~a;
			data = rand_bits(1);
			enc_pins.enc_a = a;
			enc_pins.enc_b = data[0];
			enc_exp = order_step(enc_exp, a == data[0]);	// A==B steps backward
			tick(6);	// Sync, edge detect, phase and game registers
			check("game.spinner", 8'(game.spinner), 8'(enc_exp));
		end
		enc_pins.fire_n = 1'b0;
		tick(2);
		check("game.shot_n", 8'(game.shot_n), 8'h00);
		enc_pins.fire_n = 1'b1;
		tick(2);
		check("game.shot_n", 8'(game.shot_n), 8'h01);
		send_mouse(9'sd0);	// Activity only, no motion
		tick(3);
		check("game.spinner", 8'(game.spinner), 8'(emu_exp));
		apb_access(1'b1, `ARK_ADDR_CTRL, 8'h00, rd, err);
		enc_pins.enc_a = ~a;
		tick(6);
		check("game.spinner", 8'(game.spinner), 8'(emu_exp));
		test_end("encoder source");

		$display("Tests run %0d, failed %0d, failing checks %0d",
			tests_run, tests_failed, fail_total());
		if (tests_failed == 0 && fail_total() == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

	// Run limit
	initial begin
		cycle_cnt = 0;
		while (cycle_cnt < TIMEOUT_CYC) begin
			@(posedge CLK_12M);
			cycle_cnt++;
		end
		$display("Run stopped after %0d cycles without reaching the end", TIMEOUT_CYC);
		$display("Some tests failed");
		$finish;
	end

endmodule

/* tb/arkanoid_input_sva.sv */
/*
 * Concurrent checks bound into the input front end top level
 * APB ready, DIP inversion, fire latency, phase step shape and spacing
 */
`include "arkanoid_input_settings.svh"

module arkanoid_input_sva (
	input logic                          CLK_12M,
	input logic                          rst_n,
	input arkanoid_input_pkg::apb_req_t  apb_req,
	input arkanoid_input_pkg::apb_rsp_t  apb_rsp,
	input arkanoid_input_pkg::dip_t      dip_sw,
	input arkanoid_input_pkg::ps2_key_t  ps2_key,
	input arkanoid_input_pkg::game_in_t  game,
	input arkanoid_input_pkg::quad_t     emu_phase,
	input arkanoid_input_pkg::quad_t     enc_phase
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int STEP_CYC = `ARK_CE_DIV * `ARK_STEP_DIV;	// Clocks per step tick

	int unsigned fail_cnt = 0;	// Read by the testbench
	int unsigned emu_gap;	// Cycles since the last emulated step
	logic key_tgl_q;
	logic fire_evt;
	logic emu_moved;
	logic enc_moved;
	arkanoid_input_pkg::dip_t  dip_shadow;	// Last byte written at the DIP address
	arkanoid_input_pkg::quad_t emu_prev;
	arkanoid_input_pkg::quad_t enc_prev;

	assign fire_evt  = (ps2_key.toggle != key_tgl_q) && ps2_key.pressed
		&& (ps2_key.code == `ARK_KEY_FIRE);
	assign emu_moved = (emu_phase != emu_prev);
	assign enc_moved = (enc_phase != enc_prev);

	always_ff @(posedge CLK_12M) begin
		key_tgl_q <= ps2_key.toggle;	// Follows through reset like the decoder
		if (!rst_n) begin
			dip_shadow <= '0;
			emu_prev   <= 2'b11;
			enc_prev   <= 2'b11;
			emu_gap    <= STEP_CYC;
		end else begin
			if (apb_req.psel && apb_req.penable && apb_req.pwrite
				&& apb_req.paddr == `ARK_ADDR_DIP)
				dip_shadow <= apb_req.pwdata;
			emu_prev <= emu_phase;
			enc_prev <= enc_phase;
			if (emu_moved)
				emu_gap <= 1;
			else if (emu_gap < STEP_CYC)
				emu_gap <= emu_gap + 1;	// Saturates at one step period
		end
	end

	////////////////////////////////////////////////////////////
	// Bus
	a_pready: assert property (@(posedge CLK_12M) disable iff (!rst_n)
		apb_req.psel && apb_req.penable |-> apb_rsp.pready)
		else begin fail_cnt = fail_cnt + 1; $error("pready low in an APB access"); end

	a_dip_inverse: assert property (@(posedge CLK_12M) disable iff (!rst_n)
		dip_sw == ~dip_shadow)
		else begin fail_cnt = fail_cnt + 1; $error("dip_sw not the inverse of the DIP byte"); end

	////////////////////////////////////////////////////////////
	// Buttons and spinner
	a_fire_latency: assert property (@(posedge CLK_12M) disable iff (!rst_n)
		fire_evt |-> ##2 !game.shot_n)
		else begin fail_cnt = fail_cnt + 1; $error("shot_n not low two cycles after fire"); end

	a_emu_one_bit: assert property (@(posedge CLK_12M) disable iff (!rst_n)
		emu_moved |-> $onehot(emu_phase ^ emu_prev))
		else begin fail_cnt = fail_cnt + 1; $error("emulated phase changed two bits"); end

	a_enc_one_bit: assert property (@(posedge CLK_12M) disable iff (!rst_n)
		enc_moved |-> $onehot(enc_phase ^ enc_prev))
		else begin fail_cnt = fail_cnt + 1; $error("encoder phase changed two bits"); end

	a_emu_spacing: assert property (@(posedge CLK_12M) disable iff (!rst_n)
		emu_moved |-> emu_gap >= STEP_CYC)
		else begin fail_cnt = fail_cnt + 1; $error("emulated steps closer than a step period"); end

endmodule

bind arkanoid_input arkanoid_input_sva i_sva (
	.CLK_12M   (CLK_12M),
	.rst_n     (rst_n),
	.apb_req   (apb_req),
	.apb_rsp   (apb_rsp),
	.dip_sw    (dip_sw),
	.ps2_key   (ps2_key),
	.game      (game),
	.emu_phase (emu_phase),
	.enc_phase (enc_phase)
);

/* rtl/arkanoid_input.sv */
/*
 * Top of the player input front end
 * Keyboard decoder, spinner emulator, encoder path, APB DIP bank
 * and the control block feeding the game
 */
module arkanoid_input (
	input  logic                          CLK_12M,
	input  logic                          rst_n,
	input  arkanoid_input_pkg::ps2_key_t  ps2_key,
	input  arkanoid_input_pkg::mouse_t    mouse,
	input  arkanoid_input_pkg::pad_t      pad,
	input  arkanoid_input_pkg::enc_pins_t enc_pins,
	input  arkanoid_input_pkg::apb_req_t  apb_req,
	output arkanoid_input_pkg::apb_rsp_t  apb_rsp,
	output arkanoid_input_pkg::game_in_t  game,
	output arkanoid_input_pkg::dip_t      dip_sw
);

	arkanoid_input_pkg::buttons_t keys;
	arkanoid_input_pkg::quad_t    emu_phase;
	arkanoid_input_pkg::quad_t    enc_phase;
	logic pad_left, pad_right, pad_fast;	// Key OR pad, to the emulator
	logic emu_activity;
	logic enc_moved;
	logic enc_enable;

	ps2_key_decoder i_keys (
		.CLK_12M (CLK_12M), .rst_n (rst_n), .ps2_key (ps2_key), .keys (keys)
	);

	spinner_emulator i_spin (
		.CLK_12M      (CLK_12M),
		.rst_n        (rst_n),
		.mouse        (mouse),
		.pad_left     (pad_left),
		.pad_right    (pad_right),
		.pad_fast     (pad_fast),
		.emu_phase    (emu_phase),
		.emu_activity (emu_activity)
	);

	encoder_halver i_enc (
		.CLK_12M (CLK_12M), .rst_n (rst_n), .enc_pins (enc_pins),
		.enc_phase (enc_phase), .enc_moved (enc_moved)
	);

	dip_switch_bank i_dip (
		.CLK_12M (CLK_12M), .rst_n (rst_n), .apb_req (apb_req), .apb_rsp (apb_rsp),
		.dip_sw (dip_sw), .enc_enable (enc_enable)
	);

	input_control i_ctrl (
		.CLK_12M      (CLK_12M),
		.rst_n        (rst_n),
		.keys         (keys),
		.pad          (pad),
		.mouse_btn    (mouse.btn),	// Either mouse button fires
		.fire_n       (enc_pins.fire_n),
		.emu_phase    (emu_phase),
		.emu_activity (emu_activity),
		.enc_phase    (enc_phase),
		.enc_moved    (enc_moved),
		.enc_enable   (enc_enable),
		.pad_left     (pad_left),
		.pad_right    (pad_right),
		.pad_fast     (pad_fast),
		.game         (game)
	);

endmodule

/* rtl/input_control.sv */
/*
 * Source select FSM and button merge
 * Emulated spinner vs external encoder, registered game inputs
 */
module input_control (
	input  logic                         CLK_12M,
	input  logic                         rst_n,
	input  arkanoid_input_pkg::buttons_t keys,
	input  arkanoid_input_pkg::pad_t     pad,
	input  logic [1:0]                   mouse_btn,
	input  logic                         fire_n,
	input  arkanoid_input_pkg::quad_t    emu_phase,
	input  logic                         emu_activity,
	input  arkanoid_input_pkg::quad_t    enc_phase,
	input  logic                         enc_moved,
	input  logic                         enc_enable,
	output logic                         pad_left,
	output logic                         pad_right,
	output logic                         pad_fast,
	output arkanoid_input_pkg::game_in_t game
);

	arkanoid_input_pkg::src_t     src_q, src_d;
	arkanoid_input_pkg::game_in_t game_d;
	logic fire;

	assign pad_left  = keys.left | pad.left;
	assign pad_right = keys.right | pad.right;
	assign pad_fast  = keys.fast | pad.fast;

	////////////////////////////////////////////////////////////
	// Source select, last device that moved wins
	always_comb begin
		src_d = src_q;
		case (src_q)
			arkanoid_input_pkg::SRC_EMU:
				if (enc_enable && enc_moved)
					src_d = arkanoid_input_pkg::SRC_ENCODER;
			arkanoid_input_pkg::SRC_ENCODER:
				if (!enc_enable || emu_activity)
					src_d = arkanoid_input_pkg::SRC_EMU;
			default: src_d = arkanoid_input_pkg::SRC_EMU;
		endcase
	end

	// Encoder fire pin counts only while the encoder drives
	assign fire = keys.fire | pad.fire | (|mouse_btn)
		| ((src_q == arkanoid_input_pkg::SRC_ENCODER) & ~fire_n);

	always_comb begin
		game_d.spinner   = (src_q == arkanoid_input_pkg::SRC_ENCODER) ? enc_phase : emu_phase;
		game_d.shot_n    = ~fire;
		game_d.service_n = ~keys.service;
		game_d.start1_n  = ~(keys.start1 | pad.start1);
		game_d.start2_n  = ~(keys.start2 | pad.start2);
		game_d.coin1     = keys.coin1 | pad.coin1;
		game_d.coin2     = keys.coin2;	// No pad coin 2
	end

	always_ff @(posedge CLK_12M) begin
		if (!rst_n) begin
			src_q <= arkanoid_input_pkg::SRC_EMU;
			game  <= '{spinner: 2'b11, shot_n: 1'b1, service_n: 1'b1, start1_n: 1'b1,
				start2_n: 1'b1, coin1: 1'b0, coin2: 1'b0};
		end else begin
			src_q <= src_d;
			game  <= game_d;
		end
	end

endmodule

/* rtl/dip_switch_bank.sv */
/*
 * APB register bank
 * DIP switch byte at 0, control register at 1 with the encoder enable,
 * address decode and error response
 */
`include "arkanoid_input_settings.svh"

module dip_switch_bank (
	input  logic                         CLK_12M,
	input  logic                         rst_n,
	input  arkanoid_input_pkg::apb_req_t apb_req,
	output arkanoid_input_pkg::apb_rsp_t apb_rsp,
	output arkanoid_input_pkg::dip_t     dip_sw,
	output logic                         enc_enable
);

	logic setup;
	logic access;
	logic addr_dip;
	logic addr_ctrl;
	logic enc_en_q;
	arkanoid_input_pkg::dip_t dip_q;	// Stored active high
	arkanoid_input_pkg::dip_t rd_mux;
	arkanoid_input_pkg::dip_t rdata_q;

	assign setup     = apb_req.psel & ~apb_req.penable;
	assign access    = apb_req.psel & apb_req.penable;
	assign addr_dip  = (apb_req.paddr == `ARK_ADDR_DIP);
	assign addr_ctrl = (apb_req.paddr == `ARK_ADDR_CTRL);

	always_comb begin
		rd_mux = '0;	// Unmapped reads as zero
		if (addr_dip)
			rd_mux = dip_q;
		else if (addr_ctrl)
			rd_mux = {7'b0, enc_en_q};
	end

	////////////////////////////////////////////////////////////
	// Registers
	always_ff @(posedge CLK_12M) begin
		if (!rst_n) begin
			dip_q    <= '0;
			enc_en_q <= 1'b0;
			rdata_q  <= '0;
		end else begin
			if (access && apb_req.pwrite) begin
				if (addr_dip)
					dip_q <= apb_req.pwdata;
				if (addr_ctrl)
					enc_en_q <= apb_req.pwdata[0];
			end
			// Read data captured in setup, held through access and after
			if (setup)
				rdata_q <= apb_req.pwrite ? '0 : rd_mux;
		end
	end

	always_comb begin
		apb_rsp.prdata  = rdata_q;
		apb_rsp.pready  = 1'b1;	// Never stalls
		apb_rsp.pslverr = access & ~(addr_dip | addr_ctrl);
	end

	assign dip_sw     = ~dip_q;	// Game switches are active low
	assign enc_enable = enc_en_q;

endmodule

/* rtl/encoder_halver.sv */
/*
 * External A/B encoder path
 * Pin synchronizers, A edge detect, one phase step per A edge
 */
module encoder_halver (
	input  logic                          CLK_12M,
	input  logic                          rst_n,
	input  arkanoid_input_pkg::enc_pins_t enc_pins,
	output arkanoid_input_pkg::quad_t     enc_phase,
	output logic                          enc_moved
);

	logic a_s1, a_s2, a_d;	// Two sync flops then edge history
	logic b_s1, b_s2;
	logic a_edge;
	arkanoid_input_pkg::quad_t phase_q;

	always_ff @(posedge CLK_12M) begin
		a_s1 <= enc_pins.enc_a;
		a_s2 <= a_s1;
		b_s1 <= enc_pins.enc_b;
		b_s2 <= b_s1;
		a_d  <= a_s2;	// Tracks during reset, so no false edge after
	end

	assign a_edge = a_s2 ^ a_d;

	// Only A edges count, which halves the pulse rate
	always_ff @(posedge CLK_12M) begin
		if (!rst_n)
			phase_q <= 2'b11;
		else if (a_edge)
			phase_q <= arkanoid_input_pkg::quad_next(phase_q, a_s2 ^ b_s2);	// A==B backward
	end

	assign enc_phase = phase_q;
	assign enc_moved = a_edge;

endmodule

/* rtl/spinner_emulator.sv */
/*
 * Spinner emulation from mouse motion and held pad buttons
 * 6 MHz enable, step and poll dividers, signed position accumulator,
 * quadrature phase generator draining the position toward zero
 */
`include "arkanoid_input_settings.svh"

module spinner_emulator (
	input  logic                       CLK_12M,
	input  logic                       rst_n,
	input  arkanoid_input_pkg::mouse_t mouse,
	input  logic                       pad_left,
	input  logic                       pad_right,
	input  logic                       pad_fast,
	output arkanoid_input_pkg::quad_t  emu_phase,
	output logic                       emu_activity
);

	localparam int CE_W   = $clog2(`ARK_CE_DIV);
	localparam int STEP_W = $clog2(`ARK_STEP_DIV);
	localparam int POLL_W = $clog2(`ARK_POLL_DIV);
	localparam int MSB    = `ARK_POS_W - 1;
	localparam int DX_W   = $bits(mouse.dx);

	logic [CE_W-1:0]   ce_cnt;
	logic              ce;	// 6 MHz
	logic [STEP_W-1:0] step_cnt;
	logic              step_tick;	// One per 3000 clocks
	logic [POLL_W-1:0] poll_cnt;
	logic              poll_tick;
	logic              pad_held;
	logic              mouse_tgl_q;
	logic              mouse_evt;
	logic              pos_room;	// Top two bits agree, no overflow risk
	logic              drain;

	arkanoid_input_pkg::position_t position;
	arkanoid_input_pkg::position_t pos_drained;
	arkanoid_input_pkg::position_t pad_load;
	arkanoid_input_pkg::position_t dx_ext;
	arkanoid_input_pkg::position_t pad_mag;
	arkanoid_input_pkg::quad_t     phase_q;

	////////////////////////////////////////////////////////////
	// Enable and dividers
	assign ce = (ce_cnt == CE_W'(`ARK_CE_DIV - 1));

	always_ff @(posedge CLK_12M) begin
		if (!rst_n) begin
			ce_cnt   <= '0;
			step_cnt <= '0;
		end else begin
			ce_cnt <= ce ? '0 : ce_cnt + 1'b1;
			if (ce) begin
				if (step_cnt == STEP_W'(`ARK_STEP_DIV - 1))
					step_cnt <= '0;
				else
					step_cnt <= step_cnt + 1'b1;
			end
		end
	end

	assign step_tick = ce && (step_cnt == '0);

	// Poll counter runs only while a pad direction is held
	assign pad_held  = pad_left | pad_right;
	assign poll_tick = ce && pad_held && (poll_cnt == POLL_W'(`ARK_POLL_DIV - 1));

	always_ff @(posedge CLK_12M) begin
		if (!rst_n || !pad_held)
			poll_cnt <= '0;
		else if (ce)
			poll_cnt <= (poll_tick) ? '0 : poll_cnt + 1'b1;
	end

	////////////////////////////////////////////////////////////
	// Position arithmetic
	assign mouse_evt = mouse.toggle ^ mouse_tgl_q;
	assign pos_room  = ~(position[MSB] ^ position[MSB-1]);
	assign drain     = step_tick && (position != '0);
	assign dx_ext    = {{(`ARK_POS_W - DX_W){mouse.dx[DX_W-1]}}, mouse.dx};
	assign pad_mag   = pad_fast ? `ARK_POS_W'(`ARK_FAST_STEP) : `ARK_POS_W'(`ARK_SLOW_STEP);
	assign pad_load  = pad_right ? pad_mag : -pad_mag;	// Right wins if both

	always_comb begin
		pos_drained = position;
		if (drain)
			pos_drained = position[MSB] ? position + 1'b1 : position - 1'b1;	// Toward zero
	end

	always_ff @(posedge CLK_12M) begin
		mouse_tgl_q <= mouse.toggle;	// Follows through reset
	end

	always_ff @(posedge CLK_12M) begin
		if (!rst_n) begin
			position <= '0;
			phase_q  <= 2'b11;
		end else begin
			// Negative position walks 00 01 11 10
			if (drain)
				phase_q <= arkanoid_input_pkg::quad_next(phase_q, position[MSB]);
			if (poll_tick)
				position <= pad_load;	// Pad reloads, does not add
			else if (mouse_evt && pos_room)
				position <= pos_drained + dx_ext;
			else
				position <= pos_drained;
		end
	end

	assign emu_phase    = phase_q;
	assign emu_activity = mouse_evt | poll_tick;	// Claims the source back

endmodule

/* rtl/ps2_key_decoder.sv */
/*
 * Keyboard front end
 * Toggle edge detect on the key event and nine held button states
 */
`include "arkanoid_input_settings.svh"

module ps2_key_decoder (
	input  logic                         CLK_12M,
	input  logic                         rst_n,
	input  arkanoid_input_pkg::ps2_key_t ps2_key,
	output arkanoid_input_pkg::buttons_t keys
);

	logic tgl_q;	// Last seen toggle
	logic key_evt;

	assign key_evt = ps2_key.toggle ^ tgl_q;

	// Tracks the toggle through reset too, so no stale event after it
	always_ff @(posedge CLK_12M) begin
		tgl_q <= ps2_key.toggle;
	end

	////////////////////////////////////////////////////////////
	// Button states
	always_ff @(posedge CLK_12M) begin
		if (!rst_n) begin
			keys <= '0;	// All released
		end else if (key_evt) begin
			// Make and break both land here, pressed tells which
			case (ps2_key.code)
				`ARK_KEY_START1:  keys.start1  <= ps2_key.pressed;
				`ARK_KEY_START2:  keys.start2  <= ps2_key.pressed;
				`ARK_KEY_COIN1:   keys.coin1   <= ps2_key.pressed;
				`ARK_KEY_COIN2:   keys.coin2   <= ps2_key.pressed;
				`ARK_KEY_SERVICE: keys.service <= ps2_key.pressed;
				`ARK_KEY_FAST:    keys.fast    <= ps2_key.pressed;
				`ARK_KEY_LEFT:    keys.left    <= ps2_key.pressed;
				`ARK_KEY_RIGHT:   keys.right   <= ps2_key.pressed;
				`ARK_KEY_FIRE:    keys.fire    <= ps2_key.pressed;
				default:          keys         <= keys;	// Unknown code
			endcase
		end
	end

endmodule

/* rtl/arkanoid_input_pkg.sv */
/*
 * Shared types of the input front end
 * Vector typedefs, packed event / pin / bus structs, source enum
 * and the quadrature next-phase function
 */
`include "arkanoid_input_settings.svh"

package arkanoid_input_pkg;

	typedef logic signed [`ARK_POS_W-1:0] position_t;	// Pending spinner steps
	typedef logic [1:0] quad_t;	// A/B phase
	typedef logic [7:0] dip_t;
	typedef logic [7:0] key_code_t;
	typedef logic [3:0] apb_addr_t;

	typedef struct packed {
		logic      toggle;	// Flips once per event
		logic      pressed;
		key_code_t code;
	} ps2_key_t;

	typedef struct packed {
		logic              toggle;
		logic [1:0]        btn;
		logic signed [8:0] dx;
	} mouse_t;

	typedef struct packed {
		logic right, left, fire, fast, start1, coin1, start2;
	} pad_t;

	typedef struct packed {
		logic enc_a, enc_b, fire_n;
	} enc_pins_t;

	typedef struct packed {
		logic start1, start2, coin1, coin2, service, fast, left, right, fire;
	} buttons_t;

	typedef struct packed {
		quad_t spinner;
		logic  shot_n, service_n, start1_n, start2_n;
		logic  coin1, coin2;	// Active high on this board
	} game_in_t;

	typedef struct packed {
		logic      psel, penable, pwrite;
		apb_addr_t paddr;
		dip_t      pwdata;
	} apb_req_t;

	typedef struct packed {
		dip_t prdata;
		logic pready, pslverr;
	} apb_rsp_t;

	typedef enum logic {
		SRC_EMU     = 1'b0,	// Mouse / keys / pad
		SRC_ENCODER = 1'b1	// External A/B encoder
	} src_t;

	////////////////////////////////////////////////////////////
	// Gray step, up is 00 01 11 10
	function automatic quad_t quad_next(input quad_t cur, input logic up);
		quad_t nxt;
		case (cur)
			2'b00:   nxt = up ? 2'b01 : 2'b10;
			2'b01:   nxt = up ? 2'b11 : 2'b00;
			2'b11:   nxt = up ? 2'b10 : 2'b01;
			default: nxt = up ? 2'b00 : 2'b11;
		endcase
		return nxt;
	endfunction

endpackage

/* rtl/arkanoid_input_settings.svh */
/*
 * Build-time constants for the paddle-game input front end
 * Clock enable and spinner step / poll dividers, pad step sizes,
 * PS/2 set 2 scan codes of the cabinet keys, APB register map
 */
`ifndef ARKANOID_INPUT_SETTINGS_SVH
`define ARKANOID_INPUT_SETTINGS_SVH

// Dividers, all in CLK_12M terms
`define ARK_CE_DIV      2       // 12 MHz / 2 = 6 MHz enable
`define ARK_STEP_DIV    1500    // 6 MHz ticks per quadrature step, about 4 kHz
`define ARK_POLL_DIV    48000   // 6 MHz ticks per pad poll, 8 ms like a mouse

// Pad spinner load values
`define ARK_SLOW_STEP   4
`define ARK_FAST_STEP   9
`define ARK_POS_W       12      // Position accumulator width

// Scan codes
`define ARK_KEY_START1  8'h16   // 1
`define ARK_KEY_START2  8'h1E   // 2
`define ARK_KEY_COIN1   8'h2E   // 5
`define ARK_KEY_COIN2   8'h36   // 6
`define ARK_KEY_SERVICE 8'h46   // 9
`define ARK_KEY_FAST    8'h11   // Alt
`define ARK_KEY_LEFT    8'h6B   // Cursor left
`define ARK_KEY_RIGHT   8'h74   // Cursor right
`define ARK_KEY_FIRE    8'h29   // Space

// APB map
`define ARK_ADDR_DIP    4'h0
`define ARK_ADDR_CTRL   4'h1

`endif
